// ==== rv_idecode.f ====
hdl/isa_pkg.sv
hdl/uop_pkg.sv
hdl/uop_if.sv
hdl/inst_decoder.sv
hdl/dispatch_stage.sv
hdl/next_pc_calc.sv
hdl/rv_idecode.sv
tb/tb_rv_idecode.sv

// ==== Bender.yml ====
package:
  name: rv_idecode

sources:
  - files:
      - hdl/isa_pkg.sv
      - hdl/uop_pkg.sv
      - hdl/uop_if.sv
      - hdl/inst_decoder.sv
      - hdl/dispatch_stage.sv
      - hdl/next_pc_calc.sv
      - hdl/rv_idecode.sv
  - target: test
    files:
      - tb/tb_rv_idecode.sv

// ==== tb/rv_idecode_stim.txt ====
# name word pc pred op rd rs1 rs2 imm unit redir redir_pc recover_pc
# word pc imm redir_pc recover_pc are hex, pred rd rs1 rs2 redir are decimal
add      002081b3 00001000 0 U_ADD     3  1  2  00000000 RS   0 00000000 00000000
sub      407302b3 00001004 0 U_SUB     5  6  7  00000000 RS   0 00000000 00000000
srl      00a4d433 00001008 0 U_SRL     8  9  10 00000000 RS   0 00000000 00000000
sra      40a4d433 0000100c 0 U_SRA     8  9  10 00000000 RS   0 00000000 00000000
srli     00365593 00001010 0 U_SRLI    11 12 0  00000003 RS   0 00000000 00000000
srai     41f65593 00001014 0 U_SRAI    11 12 0  0000001f RS   0 00000000 00000000
slli     00511093 00001018 0 U_SLLI    1  2  0  00000005 RS   0 00000000 00000000
addi_neg fff28213 0000101c 0 U_ADDI    4  5  0  ffffffff RS   0 00000000 00000000
andi_neg f003f313 00001020 0 U_ANDI    6  7  0  ffffff00 RS   0 00000000 00000000
xori_min 8001c113 00001024 0 U_XORI    2  3  0  fffff800 RS   0 00000000 00000000
slt      00c5a533 00001028 0 U_SLT     10 11 12 00000000 RS   0 00000000 00000000
lui_neg  fffff3b7 0000102c 0 U_LUI     7  0  0  fffff000 RS   0 00000000 00000000
auipc    12345497 00001030 0 U_AUIPC   9  0  0  12345000 RS   0 00000000 00000000
jal_fwd  010000ef 00001034 0 U_JAL     1  0  0  00000010 RS   1 00001044 00000000
jal_back ff9ff06f 00001038 0 U_JAL     0  0  0  fffffff8 RS   1 00001030 00000000
jalr_neg ffc280e7 0000103c 1 U_JALR    1  5  0  fffffffc RS   0 00000000 00001040
beq_pt   00208463 00001040 1 U_BEQ     0  1  2  00000008 RS   1 00001048 00001044
bne_pnt  fe4198e3 00001044 0 U_BNE     0  3  4  fffffff0 RS   0 00000000 00001034
blt_pt   fe62cee3 00001048 1 U_BLT     0  5  6  fffffffc RS   1 00001044 0000104c
bgeu_pnt 0083f0e3 0000104c 0 U_BGEU    0  7  8  00000800 RS   0 00000000 0000184c
lw_neg   ff412503 00001050 1 U_LW      10 2  0  fffffff4 LSB  0 00000000 00000000
lbu      06424183 00001054 0 U_LBU     3  4  0  00000064 LSB  0 00000000 00000000
sw_neg   fe532623 00001058 0 U_SW      0  6  5  ffffffec LSB  0 00000000 00000000
sb       001103a3 0000105c 0 U_SB      0  2  1  00000007 LSB  0 00000000 00000000
ill_ones ffffffff 00001060 0 U_ILLEGAL 0  0  0  00000000 NONE 0 00000000 00000000
ill_mul  023100b3 00001064 0 U_ILLEGAL 0  0  0  00000000 NONE 0 00000000 00000000

// ==== tb/tb_rv_idecode.sv ====
`timescale 1ns/1ns

module tb_rv_idecode;
    import isa_pkg::*;
    import uop_pkg::*;

    logic     clk = 1'b0;
    logic     arst_n;
    logic     inst_valid;
    logic     inst_ready;
    word_t    inst_word;
    word_t    inst_pc;
    logic     pred_taken;
    logic     flush;
    logic     rs_full;
    logic     lsb_full;
    logic     rob_full;
    logic     rs_en;
    logic     lsb_en;
    logic     rob_en;
    uop_op_e  uop_op;
    reg_idx_t uop_rd;
    reg_idx_t uop_rs1;
    reg_idx_t uop_rs2;
    word_t    uop_imm;
    word_t    uop_pc;
    logic     redirect_valid;
    word_t    redirect_pc;
    word_t    recover_pc;

    string      name_a [0:63];
    string      op_a [0:63];
    string      unit_a [0:63];
    word_t      word_a [0:63];
    word_t      pc_a [0:63];
    logic       pred_a [0:63];
    reg_idx_t   rd_a [0:63];
    reg_idx_t   rs1_a [0:63];
    reg_idx_t   rs2_a [0:63];
    word_t      imm_a [0:63];
    logic       rdir_a [0:63];
    word_t      rdpc_a [0:63];
    word_t      rec_a [0:63];
    int         n_lines = 0;

    int          expect_q [$];  // accepted but not yet dispatched
    int          errors = 0;
    int          disp_count = 0;
    int          idx;
    integer      seed;
    logic [31:0] rnd;
    logic        hold_rob = 1'b0;
    logic        stalled = 1'b0;
    logic [84:0] snap;

    rv_idecode dut (.*);

    always #10 clk = ~clk;

    // queue full flags high about one cycle in four
    always @(negedge clk) begin
        rnd      = $random(seed);
        rs_full  = (rnd[1:0] == 2'b00);
        lsb_full = (rnd[3:2] == 2'b00);
        rob_full = hold_rob || (rnd[5:4] == 2'b00);
    end

    task automatic compare_field(input string test, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("error %s %s: expected %h, actual %h", test, field, exp, act);
            errors++;
        end
    endtask

    task automatic check_dispatch(input int k);
        string t;
        logic  exp_rs;
        logic  exp_lsb;
        t       = name_a[k];
        exp_rs  = (unit_a[k] == "RS");
        exp_lsb = (unit_a[k] == "LSB");
        if (uop_op.name() != op_a[k]) begin
            $display("error %s op: expected %s, actual %s", t, op_a[k], uop_op.name());
            errors++;
        end
        compare_field(t, "rd", rd_a[k], uop_rd);
        compare_field(t, "rs1", rs1_a[k], uop_rs1);
        compare_field(t, "rs2", rs2_a[k], uop_rs2);
        compare_field(t, "imm", imm_a[k], uop_imm);
        compare_field(t, "pc", pc_a[k], uop_pc);
        compare_field(t, "rs_en", exp_rs, rs_en);
        compare_field(t, "lsb_en", exp_lsb, lsb_en);
        compare_field(t, "redirect_valid", rdir_a[k], redirect_valid);
        if (rdir_a[k]) compare_field(t, "redirect_pc", rdpc_a[k], redirect_pc);
        compare_field(t, "recover_pc", rec_a[k], recover_pc);
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            if (stalled && ({uop_op, uop_rd, uop_rs1, uop_rs2, uop_imm, uop_pc} !== snap)) begin
                $display("micro-op outputs changed while the stage was stalled");
                errors++;
            end
            if (!rob_en && (rs_en || lsb_en || redirect_valid)) begin
                $display("queue enable or redirect raised without rob_en");
                errors++;
            end
            if (!rob_en && (expect_q.size() != 0) && !rob_full && !flush) begin
                idx = expect_q[0];
                if ((unit_a[idx] == "NONE") || ((unit_a[idx] == "RS") && !rs_full)
                        || ((unit_a[idx] == "LSB") && !lsb_full)) begin
                    $display("%s was held back with room in its queues", name_a[idx]);
                    errors++;
                end
            end
            if (rob_en) begin
                if (rob_full || (rs_en && rs_full) || (lsb_en && lsb_full)) begin
                    $display("dispatch happened into a full queue");
                    errors++;
                end
                if (expect_q.size() == 0) begin
                    $display("dispatch happened with no instruction pending");
                    errors++;
                end else begin
                    idx = expect_q.pop_front();
                    check_dispatch(idx);
                    disp_count++;
                end
            end
            stalled = !rob_en && (expect_q.size() != 0);
            snap    = {uop_op, uop_rd, uop_rs1, uop_rs2, uop_imm, uop_pc};
        end
    end

    task automatic load_stim;
        int                 fd;
        int                 cnt;
        logic [8*200-1:0]   line;
        fd = $fopen("tb/rv_idecode_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stim file tb/rv_idecode_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_lines < 64) begin
                line = '0;
                cnt  = $fgets(line, fd);
                if (cnt > 0) begin
                    cnt = $sscanf(line, "%s %h %h %d %s %d %d %d %h %s %d %h %h",
                                  name_a[n_lines], word_a[n_lines], pc_a[n_lines],
                                  pred_a[n_lines], op_a[n_lines], rd_a[n_lines],
                                  rs1_a[n_lines], rs2_a[n_lines], imm_a[n_lines],
                                  unit_a[n_lines], rdir_a[n_lines], rdpc_a[n_lines],
                                  rec_a[n_lines]);
                    if (cnt == 13) n_lines++;  // header lines fall out here
                end
            end
            $fclose(fd);
        end
        if (n_lines < 2) begin
            $display("stim file holds fewer than two instructions");
            errors++;
        end
    endtask

    // drive one instruction at the falling edge and hold it until accepted
    task automatic offer_inst(input int k, input bit track);
        int w;
        bit ok;
        inst_word  = word_a[k];
        inst_pc    = pc_a[k];
        pred_taken = pred_a[k];
        inst_valid = 1'b1;
        w  = 0;
        ok = 1'b0;
        while (!ok && w < 200) begin
            @(posedge clk);
            if (inst_ready) ok = 1'b1;
            else w++;
        end
        if (!ok) begin
            $display("instruction %s was not accepted within 200 cycles", name_a[k]);
            errors++;
        end
        @(negedge clk);
        if (ok && track) expect_q.push_back(k);
        inst_valid = 1'b0;
    endtask

    task automatic wait_drain;
        int w;
        w = 0;
        while (expect_q.size() != 0 && w < 200) begin
            @(negedge clk);
            w++;
        end
        if (expect_q.size() != 0) begin
            $display("instructions still pending after 200 cycles");
            errors++;
        end
    endtask

    initial begin
        seed       = 22;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst_word  = '0;
        inst_pc    = '0;
        pred_taken = 1'b0;
        flush      = 1'b0;
        rs_full    = 1'b0;
        lsb_full   = 1'b0;
        rob_full   = 1'b0;
        load_stim();
        repeat (16) @(posedge clk);
        @(negedge clk);
        compare_field("reset", "enables", 4'b0, {rs_en, lsb_en, rob_en, redirect_valid});
        arst_n = 1'b1;
        @(posedge clk);
        compare_field("reset", "inst_ready", 1'b1, inst_ready);
        @(negedge clk);

        for (int i = 0; i < n_lines; i++) begin
            offer_inst(i, 1'b1);
        end
        wait_drain();

        // stall one micro-op behind a full rob and flush it away
        @(posedge clk);
        hold_rob = 1'b1;
        @(negedge clk);
        offer_inst(0, 1'b0);
        repeat (3) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        @(posedge clk);
        compare_field("flush", "inst_ready", 1'b1, inst_ready);
        hold_rob = 1'b0;
        @(negedge clk);
        offer_inst(1, 1'b1);
        wait_drain();
        compare_field("run", "dispatch count", n_lines + 1, disp_count);

        $display("%0d dispatches checked, %0d errors", disp_count, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== hdl/rv_idecode.sv ====
`timescale 1ns/1ns

module rv_idecode (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               inst_valid,
    output logic               inst_ready,
    input  isa_pkg::word_t     inst_word,
    input  isa_pkg::word_t     inst_pc,
    input  logic               pred_taken,
    input  logic               flush,
    input  logic               rs_full,
    input  logic               lsb_full,
    input  logic               rob_full,
    output logic               rs_en,
    output logic               lsb_en,
    output logic               rob_en,
    output uop_pkg::uop_op_e   uop_op,
    output isa_pkg::reg_idx_t  uop_rd,
    output isa_pkg::reg_idx_t  uop_rs1,
    output isa_pkg::reg_idx_t  uop_rs2,
    output isa_pkg::word_t     uop_imm,
    output isa_pkg::word_t     uop_pc,
    output logic               redirect_valid,
    output isa_pkg::word_t     redirect_pc,
    output isa_pkg::word_t     recover_pc
);

    uop_if dec_uop ();
    uop_if held_uop ();  // stage register contents

    inst_decoder u_decoder (
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .inst_pc    (inst_pc),
        .pred_taken (pred_taken),
        .uop        (dec_uop.src)
    );

    dispatch_stage u_dispatch (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .rs_full    (rs_full),
        .lsb_full   (lsb_full),
        .rob_full   (rob_full),
        .in_uop     (dec_uop.dst),
        .held       (held_uop.src),
        .inst_ready (inst_ready),
        .rs_en      (rs_en),
        .lsb_en     (lsb_en),
        .rob_en     (rob_en)
    );

    next_pc_calc u_next_pc (
        .held           (held_uop.dst),
        .rob_en         (rob_en),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .recover_pc     (recover_pc)
    );

    assign uop_op  = held_uop.op;
    assign uop_rd  = held_uop.rd;
    assign uop_rs1 = held_uop.rs1;
    assign uop_rs2 = held_uop.rs2;
    assign uop_imm = held_uop.imm;
    assign uop_pc  = held_uop.pc;

endmodule

// ==== hdl/next_pc_calc.sv ====
`timescale 1ns/1ns

module next_pc_calc (
    uop_if.dst             held,
    input  logic           rob_en,
    output logic           redirect_valid,
    output isa_pkg::word_t redirect_pc,
    output isa_pkg::word_t recover_pc
);
    import isa_pkg::*;
    import uop_pkg::*;

    word_t taken_pc;
    word_t fall_pc;
    logic  is_branch;

    assign taken_pc  = held.pc + held.imm;
    assign fall_pc   = held.pc + INST_BYTES;
    assign is_branch = held.op inside {U_BEQ, U_BNE, U_BLT, U_BGE, U_BLTU, U_BGEU};

    // fetch follows jal and predicted-taken branches
    assign redirect_valid = rob_en && ((held.op == U_JAL) || (is_branch && held.pred));
    assign redirect_pc    = redirect_valid ? taken_pc : '0;

    always_comb begin
        if (is_branch) begin
            recover_pc = held.pred ? fall_pc : taken_pc;  // the path not taken
        end else if (held.op == U_JALR) begin
            recover_pc = fall_pc;
        end else begin
            recover_pc = '0;
        end
    end

    // fetch pc and decoded offsets together must keep word alignment
    always_comb begin
        if (redirect_valid) begin
            a_redirect_align: assert final (redirect_pc[1:0] == 2'b00)
                else $error("misaligned redirect target");
        end
    end

endmodule

// ==== hdl/dispatch_stage.sv ====
`timescale 1ns/1ns

module dispatch_stage (
    input  logic clk,
    input  logic arst_n,
    input  logic flush,
    input  logic rs_full,
    input  logic lsb_full,
    input  logic rob_full,
    uop_if.dst   in_uop,
    uop_if.src   held,
    output logic inst_ready,
    output logic rs_en,
    output logic lsb_en,
    output logic rob_en
);
    import uop_pkg::*;

    logic unit_free;
    logic dispatch;
    logic load;

    always_comb begin
        case (held.unit)
            UNIT_RS:  unit_free = !rs_full;
            UNIT_LSB: unit_free = !lsb_full;
            default:  unit_free = 1'b1;  // illegal needs rob space only
        endcase
    end

    assign dispatch   = held.valid && !rob_full && unit_free && !flush;
    assign inst_ready = !flush && (!held.valid || dispatch);  // refill on dispatch
    assign load       = inst_ready && in_uop.valid;

    assign rob_en = dispatch;
    assign rs_en  = dispatch && (held.unit == UNIT_RS);
    assign lsb_en = dispatch && (held.unit == UNIT_LSB);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held.valid <= 1'b0;
        end else if (flush) begin
            held.valid <= 1'b0;
        end else if (load) begin
            held.valid <= 1'b1;
        end else if (dispatch) begin
            held.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            held.op   <= in_uop.op;
            held.unit <= in_uop.unit;
            held.rd   <= in_uop.rd;
            held.rs1  <= in_uop.rs1;
            held.rs2  <= in_uop.rs2;
            held.imm  <= in_uop.imm;
            held.pc   <= in_uop.pc;
            held.pred <= in_uop.pred;
        end
    end

    a_single_queue: assert property (@(posedge clk) disable iff (!arst_n)
        !(rs_en && lsb_en))
        else $error("rs and lsb enabled together");

    a_en_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        (rs_en || lsb_en || rob_en) |-> held.valid)
        else $error("dispatch from an empty stage");

    // a stalled micro-op must reach the queues unchanged
    a_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
        held.valid && !rob_en && !flush |=> held.valid && $stable({held.op, held.unit,
            held.rd, held.rs1, held.rs2, held.imm, held.pc, held.pred}))
        else $error("held micro-op changed while stalled");

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder (
    input  logic           inst_valid,
    input  isa_pkg::word_t inst_word,
    input  isa_pkg::word_t inst_pc,
    input  logic           pred_taken,
    uop_if.src             uop
);
    import isa_pkg::*;
    import uop_pkg::*;

    opcode_e    opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   f_rd;
    reg_idx_t   f_rs1;
    reg_idx_t   f_rs2;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_sh;
    uop_op_e    dec_op;
    exec_unit_e dec_unit;
    reg_idx_t   dec_rd;
    reg_idx_t   dec_rs1;
    reg_idx_t   dec_rs2;
    word_t      dec_imm;

    assign opc    = opcode_e'(inst_word[6:0]);
    assign funct3 = inst_word[14:12];
    assign funct7 = inst_word[31:25];
    assign f_rd   = inst_word[11:7];
    assign f_rs1  = inst_word[19:15];
    assign f_rs2  = inst_word[24:20];

    assign imm_i  = {{20{inst_word[31]}}, inst_word[31:20]};
    assign imm_s  = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
    assign imm_b  = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                     inst_word[30:25], inst_word[11:8], 1'b0};
    assign imm_u  = {inst_word[31:12], 12'b0};
    assign imm_j  = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                     inst_word[20], inst_word[30:21], 1'b0};
    assign imm_sh = {27'b0, inst_word[24:20]};  // shamt

    always_comb begin
        dec_op   = U_ILLEGAL;
        dec_unit = UNIT_RS;
        dec_rd   = '0;
        dec_rs1  = '0;
        dec_rs2  = '0;
        dec_imm  = '0;
        case (opc)
            OPC_LUI: begin
                dec_op  = U_LUI;
                dec_rd  = f_rd;
                dec_imm = imm_u;
            end
            OPC_AUIPC: begin
                dec_op  = U_AUIPC;
                dec_rd  = f_rd;
                dec_imm = imm_u;
            end
            OPC_JAL: begin
                dec_op  = U_JAL;
                dec_rd  = f_rd;
                dec_imm = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == F3_JALR) dec_op = U_JALR;
                dec_rd  = f_rd;
                dec_rs1 = f_rs1;
                dec_imm = imm_i;
            end
            OPC_BRANCH: begin
                dec_rs1 = f_rs1;
                dec_rs2 = f_rs2;
                dec_imm = imm_b;
                case (funct3)
                    F3_BEQ:  dec_op = U_BEQ;
                    F3_BNE:  dec_op = U_BNE;
                    F3_BLT:  dec_op = U_BLT;
                    F3_BGE:  dec_op = U_BGE;
                    F3_BLTU: dec_op = U_BLTU;
                    F3_BGEU: dec_op = U_BGEU;
                    default: dec_op = U_ILLEGAL;
                endcase
            end
            OPC_LOAD: begin
                dec_unit = UNIT_LSB;
                dec_rd   = f_rd;
                dec_rs1  = f_rs1;
                dec_imm  = imm_i;
                case (funct3)
                    F3_B:    dec_op = U_LB;
                    F3_H:    dec_op = U_LH;
                    F3_W:    dec_op = U_LW;
                    F3_BU:   dec_op = U_LBU;
                    F3_HU:   dec_op = U_LHU;
                    default: dec_op = U_ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                dec_unit = UNIT_LSB;
                dec_rs1  = f_rs1;
                dec_rs2  = f_rs2;
                dec_imm  = imm_s;
                case (funct3)
                    F3_B:    dec_op = U_SB;
                    F3_H:    dec_op = U_SH;
                    F3_W:    dec_op = U_SW;
                    default: dec_op = U_ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                dec_rd  = f_rd;
                dec_rs1 = f_rs1;
                dec_imm = imm_i;
                case (funct3)
                    F3_ADD:  dec_op = U_ADDI;
                    F3_SLT:  dec_op = U_SLTI;
                    F3_SLTU: dec_op = U_SLTIU;
                    F3_XOR:  dec_op = U_XORI;
                    F3_OR:   dec_op = U_ORI;
                    F3_AND:  dec_op = U_ANDI;
                    F3_SLL: begin
                        dec_imm = imm_sh;
                        if (funct7 == F7_BASE) dec_op = U_SLLI;
                    end
                    F3_SR: begin
                        dec_imm = imm_sh;
                        if (funct7 == F7_BASE) dec_op = U_SRLI;
                        else if (funct7 == F7_ALT) dec_op = U_SRAI;
                    end
                endcase
            end
            OPC_OP: begin
                dec_rd  = f_rd;
                dec_rs1 = f_rs1;
                dec_rs2 = f_rs2;
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD:  dec_op = U_ADD;
                        F3_SLL:  dec_op = U_SLL;
                        F3_SLT:  dec_op = U_SLT;
                        F3_SLTU: dec_op = U_SLTU;
                        F3_XOR:  dec_op = U_XOR;
                        F3_SR:   dec_op = U_SRL;
                        F3_OR:   dec_op = U_OR;
                        F3_AND:  dec_op = U_AND;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    if (funct3 == F3_ADD) dec_op = U_SUB;
                    else if (funct3 == F3_SR) dec_op = U_SRA;
                end
            end
            default: dec_op = U_ILLEGAL;
        endcase

        // unmatched encodings carry no operands
        if (dec_op == U_ILLEGAL) begin
            dec_unit = UNIT_NONE;
            dec_rd   = '0;
            dec_rs1  = '0;
            dec_rs2  = '0;
            dec_imm  = '0;
        end
    end

    assign uop.valid = inst_valid;
    assign uop.op    = dec_op;
    assign uop.unit  = dec_unit;
    assign uop.rd    = dec_rd;
    assign uop.rs1   = dec_rs1;
    assign uop.rs2   = dec_rs2;
    assign uop.imm   = dec_imm;
    assign uop.pc    = inst_pc;
    assign uop.pred  = pred_taken;

endmodule

// ==== hdl/uop_if.sv ====
`timescale 1ns/1ns

interface uop_if;
    import isa_pkg::*;
    import uop_pkg::*;

    logic       valid;
    uop_op_e    op;
    exec_unit_e unit;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm;
    word_t      pc;
    logic       pred;  // predictor taken bit

    modport src (
        output valid, op, unit, rd, rs1, rs2, imm, pc, pred
    );

    modport dst (
        input valid, op, unit, rd, rs1, rs2, imm, pc, pred
    );

endinterface

// ==== hdl/uop_pkg.sv ====
package uop_pkg;

    typedef enum logic [5:0] {
        // register-register
        U_ADD, U_SUB, U_SLL, U_SLT, U_SLTU,
        U_XOR, U_SRL, U_SRA, U_OR, U_AND,
        // register-immediate
        U_ADDI, U_SLTI, U_SLTIU, U_XORI, U_ORI, U_ANDI,
        U_SLLI, U_SRLI, U_SRAI,
        // upper immediates and jumps
        U_LUI, U_AUIPC, U_JAL, U_JALR,
        // conditional branches
        U_BEQ, U_BNE, U_BLT, U_BGE, U_BLTU, U_BGEU,
        // memory
        U_LB, U_LH, U_LW, U_LBU, U_LHU,
        U_SB, U_SH, U_SW,
        U_ILLEGAL
    } uop_op_e;

    // target queue of a micro-op
    typedef enum logic [1:0] {
        UNIT_RS   = 2'd0,
        UNIT_LSB  = 2'd1,
        UNIT_NONE = 2'd2  // reorder buffer entry only
    } exec_unit_e;

endpackage

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    localparam word_t INST_BYTES = 32'd4;  // no compressed forms

    // alu funct3 shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl / sra by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    // branch compare
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load/store width
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

endpackage
